// File: rtl/compressed_decoder.sv
`timescale 1ns/1ps

module compressed_decoder import fetch_pkg::*; (
  input  instr_t instr_i,
  output instr_t instr_o,
  output logic   is_compressed_o,
  output logic   illegal_instr_o
);

  // ------------------------------
  // RVC expansion
  // ------------------------------

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o         = '0;
    illegal_instr_o = 1'b0;

    unique case (instr_i[1:0])
      // quadrant 0
      2'b00: begin
        unique case (instr_i[15:13])
          // c.lw -> lw rd', uimm(rs1')
          3'b010: instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                             2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], OPC_LOAD};
          // c.sw -> sw rs2', uimm(rs1')
          3'b110: instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                             2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                             2'b00, OPC_STORE};
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // quadrant 1
      2'b01: begin
        unique case (instr_i[15:13])
          // c.addi -> addi rd, rd, imm
          3'b000: instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                             3'b000, instr_i[11:7], OPC_OP_IMM};
          // c.li -> addi rd, x0, imm
          3'b010: instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                             3'b000, instr_i[11:7], OPC_OP_IMM};
          // c.lui -> lui rd, imm, rd x2 would be c.addi16sp
          3'b011: begin
            instr_o = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7], OPC_LUI};
            if ((instr_i[11:7] == 5'd2) || ({instr_i[12], instr_i[6:2]} == 6'd0)) begin
              instr_o         = '0;
              illegal_instr_o = 1'b1;
            end
          end
          // c.j -> jal x0, offset
          3'b101: instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                             instr_i[2], instr_i[11], instr_i[5:3], instr_i[12],
                             {8{instr_i[12]}}, 5'b0, OPC_JAL};
          default: illegal_instr_o = 1'b1;
        endcase
      end

      // quadrant 2
      2'b10: begin
        // only c.mv and c.add, rs2 of zero is a jump form
        if ((instr_i[15:13] == 3'b100) && (instr_i[6:2] != 5'd0)) begin
          if (instr_i[12]) begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0, instr_i[6:2], instr_i[11:7], 3'b000, instr_i[11:7], OPC_OP};
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0, instr_i[6:2], 5'b0, 3'b000, instr_i[11:7], OPC_OP};
          end
        end else begin
          illegal_instr_o = 1'b1;
        end
      end

      // full width instruction passes through
      default: instr_o = instr_i;
    endcase
  end

endmodule

// File: rtl/fetch_pkg.sv
package fetch_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // byte address of an instruction or fetch word
  typedef logic [31:0] addr_t;
  // raw or expanded instruction word
  typedef logic [31:0] instr_t;
  // upper bits of a trap handler address
  typedef logic [23:0] trap_base_t;

  // ------------------------------
  // mux selectors
  // ------------------------------

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_URET      = 3'd5
  } pc_mux_e;

  // base handler or vectored interrupt entry
  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'd0,
    EXC_PC_IRQ       = 3'd1
  } exc_pc_mux_e;

  // which trap base register is used
  typedef enum logic {
    TRAP_MACHINE = 1'b0,
    TRAP_USER    = 1'b1
  } trap_mux_e;

  // fetch FSM, idle until the first request
  typedef enum logic {
    IDLE = 1'b0,
    WAIT = 1'b1
  } fetch_fsm_e;

  // number of hardware loops
  localparam int N_HWLP = 2;

  // RV32I major opcodes used by the RVC expander
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;

endpackage

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_i,
  input  trap_base_t              m_trap_base_addr_i,
  input  trap_base_t              u_trap_base_addr_i,
  input  trap_mux_e               trap_addr_mux_i,
  input  logic       [30:0]       boot_addr_i,
  output logic                    instr_req_o,
  output addr_t                   instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  instr_t                  instr_rdata_i,
  output logic       [N_HWLP-1:0] hwlp_dec_cnt_id_o,
  output logic                    is_hwlp_id_o,
  output logic                    instr_valid_id_o,
  output instr_t                  instr_rdata_id_o,
  output logic                    is_compressed_id_o,
  output logic                    illegal_c_insn_id_o,
  output addr_t                   pc_if_o,
  output addr_t                   pc_id_o,
  input  logic                    clear_instr_valid_i,
  input  logic                    pc_set_i,
  input  addr_t                   mepc_i,
  input  addr_t                   uepc_i,
  input  pc_mux_e                 pc_mux_i,
  input  exc_pc_mux_e             exc_pc_mux_i,
  input  logic       [4:0]        exc_vec_pc_mux_i,
  input  addr_t                   jump_target_id_i,
  input  addr_t                   jump_target_ex_i,
  input  addr_t      [N_HWLP-1:0] hwlp_start_i,
  input  addr_t      [N_HWLP-1:0] hwlp_end_i,
  input  addr_t      [N_HWLP-1:0] hwlp_cnt_i,
  input  logic                    halt_if_i,
  input  logic                    id_ready_i,
  output logic                    if_busy_o
);

  fetch_fsm_e        fsm_cs, fsm_ns;
  logic              valid;
  logic              if_valid;
  logic              branch_req;
  addr_t             branch_addr;
  addr_t             fetch_addr_n;
  addr_t             boot_pc;
  addr_t             exc_pc;
  trap_base_t        trap_base;
  // prefetch side
  logic              fetch_valid;
  logic              fetch_ready;
  instr_t            fetch_rdata;
  addr_t             fetch_addr;
  logic              fetch_is_hwlp;
  // hardware loops
  logic              hwlp_jump;
  logic              hwlp_pulse;
  addr_t             hwlp_target;
  logic [N_HWLP-1:0] hwlp_dec_cnt, hwlp_dec_cnt_if;
  logic              is_hwlp_id_q;
  // expander
  instr_t            instr_decompressed;
  logic              instr_compressed;
  logic              illegal_c_insn;

  // ------------------------------
  // next pc selection
  // ------------------------------

  assign boot_pc   = {boot_addr_i, 1'b0};
  assign trap_base = (trap_addr_mux_i == TRAP_USER) ? u_trap_base_addr_i : m_trap_base_addr_i;

  // plain exceptions share one entry, interrupts are vectored by 4 bytes
  always_comb begin
    exc_pc = {trap_base, 8'h00};
    if (exc_pc_mux_i == EXC_PC_IRQ) begin
      exc_pc = {trap_base, 1'b0, exc_vec_pc_mux_i, 2'b00};
    end
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT:      fetch_addr_n = boot_pc;
      PC_JUMP:      fetch_addr_n = jump_target_id_i;
      PC_BRANCH:    fetch_addr_n = jump_target_ex_i;
      PC_EXCEPTION: fetch_addr_n = exc_pc;
      PC_MRET:      fetch_addr_n = mepc_i;
      PC_URET:      fetch_addr_n = uepc_i;
      default:      fetch_addr_n = boot_pc;
    endcase
  end

  // first request out of idle always starts at the boot address
  assign branch_addr = ((fsm_cs == IDLE) && !pc_set_i) ? boot_pc : fetch_addr_n;

  // ------------------------------
  // fetch FSM
  // ------------------------------

  always_comb begin
    fsm_ns     = fsm_cs;
    branch_req = 1'b0;
    unique case (fsm_cs)
      IDLE: begin
        if (req_i) begin
          branch_req = 1'b1;
          fsm_ns     = WAIT;
        end
      end
      default: fsm_ns = WAIT;
    endcase
    // redirect from ID/EX/controller
    if (pc_set_i) begin
      branch_req = 1'b1;
      fsm_ns     = WAIT;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      fsm_cs <= IDLE;
    end else begin
      fsm_cs <= fsm_ns;
    end
  end

  // old queue contents never reach ID on a redirect
  assign valid       = (fsm_cs == WAIT) & fetch_valid & ~pc_set_i;
  assign if_valid    = valid & id_ready_i & ~halt_if_i;
  assign fetch_ready = if_valid;

  // loop jump only when the loop end instruction really moves on
  assign hwlp_pulse = hwlp_jump & fetch_ready;

  prefetch_buffer i_prefetch_buffer (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (req_i),
    .branch_i        (branch_req),
    .addr_i          ({branch_addr[31:1], 1'b0}),
    .hwloop_i        (hwlp_pulse),
    .hwloop_target_i (hwlp_target),
    .ready_i         (fetch_ready),
    .valid_o         (fetch_valid),
    .rdata_o         (fetch_rdata),
    .addr_o          (fetch_addr),
    .is_hwlp_o       (fetch_is_hwlp),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .busy_o          (if_busy_o)
  );

  hwloop_controller i_hwloop_controller (
    .current_pc_i     (fetch_addr),
    .hwlp_start_i     (hwlp_start_i),
    .hwlp_end_i       (hwlp_end_i),
    .hwlp_cnt_i       (hwlp_cnt_i),
    .hwlp_jump_o      (hwlp_jump),
    .hwlp_targ_addr_o (hwlp_target),
    .hwlp_dec_cnt_o   (hwlp_dec_cnt)
  );

  compressed_decoder i_compressed_decoder (
    .instr_i         (fetch_rdata),
    .instr_o         (instr_decompressed),
    .is_compressed_o (instr_compressed),
    .illegal_instr_o (illegal_c_insn)
  );

  assign pc_if_o = fetch_addr;

  // ------------------------------
  // IF/ID registers
  // ------------------------------

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      hwlp_dec_cnt_if   <= '0;
      hwlp_dec_cnt_id_o <= '0;
      is_hwlp_id_q      <= 1'b0;
      instr_valid_id_o  <= 1'b0;
    end else begin
      // remember which counter the pending loop target belongs to
      if (hwlp_pulse) begin
        hwlp_dec_cnt_if <= hwlp_dec_cnt;
      end
      if (if_valid) begin
        instr_valid_id_o <= 1'b1;
        is_hwlp_id_q     <= fetch_is_hwlp;
        if (fetch_is_hwlp) begin
          hwlp_dec_cnt_id_o <= hwlp_dec_cnt_if;
        end
      end else if (clear_instr_valid_i) begin
        instr_valid_id_o <= 1'b0;
      end
    end
  end

  // instruction payload, frozen under stall
  always_ff @(posedge clk) begin
    if (if_valid) begin
      instr_rdata_id_o    <= instr_decompressed;
      is_compressed_id_o  <= instr_compressed;
      illegal_c_insn_id_o <= illegal_c_insn;
      pc_id_o             <= fetch_addr;
    end
  end

  assign is_hwlp_id_o = is_hwlp_id_q & instr_valid_id_o;

endmodule

// File: rtl/hwloop_controller.sv
`timescale 1ns/1ps

module hwloop_controller import fetch_pkg::*; (
  input  addr_t                    current_pc_i,
  input  addr_t [N_HWLP-1:0]       hwlp_start_i,
  input  addr_t [N_HWLP-1:0]       hwlp_end_i,
  input  addr_t [N_HWLP-1:0]       hwlp_cnt_i,
  output logic                     hwlp_jump_o,
  output addr_t                    hwlp_targ_addr_o,
  output logic  [N_HWLP-1:0]       hwlp_dec_cnt_o
);

  // ------------------------------
  // end address match
  // ------------------------------

  // scan from the highest index down so loop 0 has the last word
  always_comb begin
    hwlp_jump_o      = 1'b0;
    hwlp_targ_addr_o = '0;
    hwlp_dec_cnt_o   = '0;

    for (int i = N_HWLP - 1; i >= 0; i--) begin
      // a counter of 1 means the last pass, fall through
      if ((current_pc_i == hwlp_end_i[i]) && (hwlp_cnt_i[i] > 32'd1)) begin
        hwlp_jump_o       = 1'b1;
        hwlp_targ_addr_o  = hwlp_start_i[i];
        hwlp_dec_cnt_o    = '0;
        hwlp_dec_cnt_o[i] = 1'b1;
      end
    end
  end

endmodule

// File: rtl/prefetch_buffer.sv
`timescale 1ns/1ps

module prefetch_buffer import fetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   req_i,
  input  logic   branch_i,
  input  addr_t  addr_i,
  input  logic   hwloop_i,
  input  addr_t  hwloop_target_i,
  input  logic   ready_i,
  output logic   valid_o,
  output instr_t rdata_o,
  output addr_t  addr_o,
  output logic   is_hwlp_o,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  output logic   busy_o
);

  // word queue, entry 0 always holds the word of the current pc
  instr_t     queue_q [2];
  instr_t     queue_n [2];
  logic [1:0] cnt_q, cnt_n;
  // granted requests not yet answered, and how many of them are stale
  logic [1:0] out_q, out_n;
  logic [1:0] disc_q, disc_n;
  addr_t      pc_q, pc_n;
  addr_t      fetch_addr_q, fetch_addr_n;
  logic       is_hwlp_q, is_hwlp_n;

  logic       redirect;
  addr_t      redirect_addr;
  logic [2:0] used;
  logic       is_32bit;
  logic       consume;
  logic       pop;
  logic [1:0] cnt_pop;
  addr_t      pc_next;

  // ------------------------------
  // realignment
  // ------------------------------

  always_comb begin
    if (pc_q[1]) begin
      // upper half of the head word, may need the lower half of the next one
      is_32bit = (queue_q[0][17:16] == 2'b11);
      if (is_32bit) begin
        rdata_o = {queue_q[1][15:0], queue_q[0][31:16]};
        valid_o = (cnt_q == 2'd2);
      end else begin
        rdata_o = {16'h0000, queue_q[0][31:16]};
        valid_o = (cnt_q != 2'd0);
      end
    end else begin
      is_32bit = (queue_q[0][1:0] == 2'b11);
      rdata_o  = queue_q[0];
      valid_o  = (cnt_q != 2'd0);
    end
  end

  assign consume = valid_o & ready_i;
  assign pc_next = pc_q + (is_32bit ? 32'd4 : 32'd2);
  // head word is done once the pc leaves it
  assign pop     = consume & (pc_next[31:2] != pc_q[31:2]);

  assign addr_o    = pc_q;
  assign is_hwlp_o = is_hwlp_q;

  // ------------------------------
  // memory request
  // ------------------------------

  // branch wins over a loop jump
  assign redirect      = branch_i | hwloop_i;
  assign redirect_addr = branch_i ? addr_i : hwloop_target_i;

  // queued words plus live requests must fit in the queue
  assign used = {1'b0, cnt_q} + {1'b0, out_q - disc_q};

  // a redirect flushes the queue so only the outstanding limit applies
  assign instr_req_o  = req_i & (out_q != 2'd2) & (redirect | (used < 3'd2));
  assign instr_addr_o = redirect ? {redirect_addr[31:2], 2'b00} : fetch_addr_q;

  assign busy_o = instr_req_o | (out_q != 2'd0);

  // ------------------------------
  // next state
  // ------------------------------

  always_comb begin
    queue_n      = queue_q;
    cnt_n        = cnt_q;
    disc_n       = disc_q;
    pc_n         = pc_q;
    fetch_addr_n = fetch_addr_q;
    is_hwlp_n    = is_hwlp_q;
    cnt_pop      = cnt_q - {1'b0, pop};
    out_n        = out_q + {1'b0, instr_req_o & instr_gnt_i} - {1'b0, instr_rvalid_i};

    // sequential word address follows the last granted one
    if (instr_req_o && instr_gnt_i) begin
      fetch_addr_n = instr_addr_o + 32'd4;
    end else if (redirect) begin
      fetch_addr_n = {redirect_addr[31:2], 2'b00};
    end

    if (redirect) begin
      // flush, everything still in flight belongs to the old stream
      cnt_n     = 2'd0;
      pc_n      = {redirect_addr[31:1], 1'b0};
      is_hwlp_n = ~branch_i;
      disc_n    = out_q - {1'b0, instr_rvalid_i};
    end else begin
      if (pop) begin
        queue_n[0] = queue_q[1];
      end
      if (consume) begin
        pc_n      = pc_next;
        is_hwlp_n = 1'b0;
      end
      if (instr_rvalid_i) begin
        if (disc_q != 2'd0) begin
          // stale response, drop it
          disc_n = disc_q - 2'd1;
        end else begin
          queue_n[cnt_pop[0]] = instr_rdata_i;
          cnt_pop             = cnt_pop + 2'd1;
        end
      end
      cnt_n = cnt_pop;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q        <= 2'd0;
      out_q        <= 2'd0;
      disc_q       <= 2'd0;
      pc_q         <= '0;
      fetch_addr_q <= '0;
      is_hwlp_q    <= 1'b0;
    end else begin
      cnt_q        <= cnt_n;
      out_q        <= out_n;
      disc_q       <= disc_n;
      pc_q         <= pc_n;
      fetch_addr_q <= fetch_addr_n;
      is_hwlp_q    <= is_hwlp_n;
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    queue_q <= queue_n;
  end

endmodule

// File: tb/tb_fetch_stage.sv
`timescale 1ns/1ps

module tb_fetch_stage import fetch_pkg::*; ();

  logic                     clk;
  logic                     rst_n;
  logic                     req_i;
  trap_base_t               m_trap_base_addr_i;
  trap_base_t               u_trap_base_addr_i;
  trap_mux_e                trap_addr_mux_i;
  logic       [30:0]        boot_addr_i;
  logic                     instr_req_o;
  addr_t                    instr_addr_o;
  logic                     instr_gnt_i;
  logic                     instr_rvalid_i;
  instr_t                   instr_rdata_i;
  logic       [N_HWLP-1:0]  hwlp_dec_cnt_id_o;
  logic                     is_hwlp_id_o;
  logic                     instr_valid_id_o;
  instr_t                   instr_rdata_id_o;
  logic                     is_compressed_id_o;
  logic                     illegal_c_insn_id_o;
  addr_t                    pc_if_o;
  addr_t                    pc_id_o;
  logic                     clear_instr_valid_i;
  logic                     pc_set_i;
  addr_t                    mepc_i;
  addr_t                    uepc_i;
  pc_mux_e                  pc_mux_i;
  exc_pc_mux_e              exc_pc_mux_i;
  logic       [4:0]         exc_vec_pc_mux_i;
  addr_t                    jump_target_id_i;
  addr_t                    jump_target_ex_i;
  addr_t      [N_HWLP-1:0]  hwlp_start_i;
  addr_t      [N_HWLP-1:0]  hwlp_end_i;
  addr_t      [N_HWLP-1:0]  hwlp_cnt_i;
  logic                     halt_if_i;
  logic                     id_ready_i;
  logic                     if_busy_o;

  // memory model state
  instr_t      mem [1024];
  integer      seed;
  int          gnt_delay;
  addr_t       gnt_addr;
  logic        pend_valid;
  addr_t       pend_addr;

  // scenario table, one row per redirect
  pc_mux_e     row_mux [16];
  exc_pc_mux_e row_exc [16];
  trap_mux_e   row_trap [16];
  logic [4:0]  row_vec [16];
  addr_t       row_tgt [16];
  addr_t       row_cnt [16];
  int          row_stall [16];
  int          row_first [16];
  int          n_rows;
  // expected IF/ID contents, in order
  addr_t       e_pc [64];
  instr_t      e_instr [64];
  logic        e_comp [64];
  logic        e_ill [64];
  logic        e_hwlp [64];
  int          n_exp;

  instr_t      x_big;
  instr_t      x_li;
  instr_t      x_addi;
  instr_t      x_mv;
  instr_t      x_add;
  instr_t      x_lui;
  instr_t      x_j;
  instr_t      x_lw;
  instr_t      x_sw;

  fetch_stage i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // RV32I encoders
  // ------------------------------

  function automatic instr_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic instr_t enc_r(logic [4:0] rs2, logic [4:0] rs1, logic [4:0] rd);
    return {7'b0, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic instr_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // default memory word, a 32-bit OP-IMM word built from the word address
  function automatic instr_t fill_word(addr_t a);
    return {a[26:2], OPC_OP_IMM};
  endfunction

  // ------------------------------
  // memory model
  // ------------------------------

  // decisions are made just after the falling edge once req has settled
  always @(negedge clk) begin
    #1;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    if (pend_valid) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem[pend_addr[11:2]];
      pend_valid     = 1'b0;
    end
    instr_gnt_i = 1'b0;
    if (instr_req_o) begin
      if (gnt_delay == 0) begin
        instr_gnt_i = 1'b1;
        gnt_addr    = instr_addr_o;
      end else begin
        gnt_delay = gnt_delay - 1;
      end
    end
    #1;
    if (instr_gnt_i && !instr_req_o) begin
      $display("grant without request on the instruction port at %0t", $time);
      $display("*** TEST FAILED ***");
      $fatal(1, "memory protocol error");
    end
  end

  always @(posedge clk) begin
    if (instr_gnt_i) begin
      pend_valid = 1'b1;
      pend_addr  = gnt_addr;
      gnt_delay  = $unsigned($random(seed)) % 3;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic add_row(pc_mux_e m, exc_pc_mux_e e, trap_mux_e t, logic [4:0] vec,
                         addr_t tgt, addr_t cnt, int stall);
    row_mux[n_rows]   = m;
    row_exc[n_rows]   = e;
    row_trap[n_rows]  = t;
    row_vec[n_rows]   = vec;
    row_tgt[n_rows]   = tgt;
    row_cnt[n_rows]   = cnt;
    row_stall[n_rows] = stall;
    row_first[n_rows] = n_exp;
    n_rows            = n_rows + 1;
  endtask

  task automatic add_exp(addr_t pc, instr_t instr, logic comp, logic ill, logic hwlp);
    e_pc[n_exp]    = pc;
    e_instr[n_exp] = instr;
    e_comp[n_exp]  = comp;
    e_ill[n_exp]   = ill;
    e_hwlp[n_exp]  = hwlp;
    n_exp          = n_exp + 1;
  endtask

  // let exactly one instruction move into IF/ID, clear drops the old one
  task automatic next_instr();
    int cycles;
    cycles              = 0;
    id_ready_i          = 1'b1;
    clear_instr_valid_i = 1'b1;
    do begin
      @(posedge clk);
      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > 40) begin
        $display("timeout waiting for instr_valid_id_o at %0t", $time);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
      end
    end while (!instr_valid_id_o);
    id_ready_i          = 1'b0;
    clear_instr_valid_i = 1'b0;
  endtask

  // IF/ID must hold under both kinds of stall
  task automatic stall_check(int n);
    addr_t  pc_hold;
    instr_t instr_hold;
    pc_hold    = pc_id_o;
    instr_hold = instr_rdata_id_o;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check_value(pc_id_o, pc_hold, "pc_id_o under id stall");
      check_value(instr_rdata_id_o, instr_hold, "instr_rdata_id_o under id stall");
    end
    id_ready_i = 1'b1;
    halt_if_i  = 1'b1;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check_value(pc_id_o, pc_hold, "pc_id_o under halt");
      check_value(instr_rdata_id_o, instr_hold, "instr_rdata_id_o under halt");
      check_value(instr_valid_id_o, 1'b1, "instr_valid_id_o under halt");
    end
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b0;
    clear_instr_valid_i = 1'b1;
    @(negedge clk);
    check_value(instr_valid_id_o, 1'b0, "instr_valid_id_o after clear");
    clear_instr_valid_i = 1'b0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int last;
    rst_n = 1'b0;
    req_i = 1'b0;
    m_trap_base_addr_i  = 24'h000001;
    u_trap_base_addr_i  = 24'h000002;
    trap_addr_mux_i     = TRAP_MACHINE;
    boot_addr_i         = 31'h40;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    clear_instr_valid_i = 1'b0;
    pc_set_i            = 1'b0;
    mepc_i              = '0;
    uepc_i              = '0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXCEPTION;
    exc_vec_pc_mux_i    = '0;
    jump_target_id_i    = '0;
    jump_target_ex_i    = '0;
    hwlp_start_i        = {32'h300, 32'hf00};
    hwlp_end_i          = {32'h308, 32'hf08};
    hwlp_cnt_i          = '0;
    halt_if_i           = 1'b0;
    id_ready_i          = 1'b0;
    seed                = 32'h62f4;
    gnt_delay           = 0;
    gnt_addr            = '0;
    pend_valid          = 1'b0;
    pend_addr           = '0;
    n_rows              = 0;
    n_exp               = 0;

    // expansions from the RV32I formats
    x_big  = enc_i(12'h123, 5'd1, 3'b000, 5'd2, OPC_OP_IMM);
    x_li   = enc_i(12'd5, 5'd0, 3'b000, 5'd10, OPC_OP_IMM);
    x_addi = enc_i(12'd1, 5'd10, 3'b000, 5'd10, OPC_OP_IMM);
    x_mv   = enc_r(5'd10, 5'd0, 5'd11);
    x_add  = enc_r(5'd10, 5'd11, 5'd11);
    x_lui  = {20'h00001, 5'd12, OPC_LUI};
    x_j    = enc_j(21'd8, 5'd0);
    x_lw   = enc_i(12'd4, 5'd8, 3'b010, 5'd9, OPC_LOAD);
    x_sw   = enc_s(12'd8, 5'd9, 5'd8);

    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(i * 4);
    end
    // boot program, mixed widths with one 32-bit word across 0x84
    mem[32'h80 >> 2] = {x_big[15:0], 16'h4515};
    mem[32'h84 >> 2] = {16'h0505, x_big[31:16]};
    mem[32'h88 >> 2] = {16'h95aa, 16'h85aa};
    mem[32'h8c >> 2] = {16'ha021, 16'h6605};
    mem[32'h90 >> 2] = {16'hc404, 16'h4044};
    mem[32'h98 >> 2] = {16'h4515, 16'h0000};

    add_row(PC_BOOT, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0, 32'd0, 3);
    add_exp(32'h80, x_li, 1'b1, 1'b0, 1'b0);
    add_exp(32'h82, x_big, 1'b0, 1'b0, 1'b0);
    add_exp(32'h86, x_addi, 1'b1, 1'b0, 1'b0);
    add_exp(32'h88, x_mv, 1'b1, 1'b0, 1'b0);
    add_exp(32'h8a, x_add, 1'b1, 1'b0, 1'b0);
    add_exp(32'h8c, x_lui, 1'b1, 1'b0, 1'b0);
    add_exp(32'h8e, x_j, 1'b1, 1'b0, 1'b0);
    add_exp(32'h90, x_lw, 1'b1, 1'b0, 1'b0);
    add_exp(32'h92, x_sw, 1'b1, 1'b0, 1'b0);
    add_exp(32'h94, fill_word(32'h94), 1'b0, 1'b0, 1'b0);
    add_exp(32'h98, 32'h0, 1'b1, 1'b1, 1'b0);
    add_exp(32'h9a, x_li, 1'b1, 1'b0, 1'b0);
    add_exp(32'h9c, fill_word(32'h9c), 1'b0, 1'b0, 1'b0);
    add_exp(32'ha0, fill_word(32'ha0), 1'b0, 1'b0, 1'b0);
    add_row(PC_JUMP, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h90, 32'd0, 0);
    add_exp(32'h90, x_lw, 1'b1, 1'b0, 1'b0);
    add_exp(32'h92, x_sw, 1'b1, 1'b0, 1'b0);
    add_exp(32'h94, fill_word(32'h94), 1'b0, 1'b0, 1'b0);
    add_row(PC_BRANCH, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h8a, 32'd0, 0);
    add_exp(32'h8a, x_add, 1'b1, 1'b0, 1'b0);
    add_exp(32'h8c, x_lui, 1'b1, 1'b0, 1'b0);
    // trap entries, base followed by 8 zero bits or by 0, vector, 00
    add_row(PC_EXCEPTION, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd3, 32'h0, 32'd0, 0);
    add_exp(32'h100, fill_word(32'h100), 1'b0, 1'b0, 1'b0);
    add_exp(32'h104, fill_word(32'h104), 1'b0, 1'b0, 1'b0);
    add_row(PC_EXCEPTION, EXC_PC_EXCEPTION, TRAP_USER, 5'd3, 32'h0, 32'd0, 0);
    add_exp(32'h200, fill_word(32'h200), 1'b0, 1'b0, 1'b0);
    add_exp(32'h204, fill_word(32'h204), 1'b0, 1'b0, 1'b0);
    add_row(PC_EXCEPTION, EXC_PC_IRQ, TRAP_MACHINE, 5'd3, 32'h0, 32'd0, 0);
    add_exp(32'h10c, fill_word(32'h10c), 1'b0, 1'b0, 1'b0);
    add_exp(32'h110, fill_word(32'h110), 1'b0, 1'b0, 1'b0);
    add_row(PC_EXCEPTION, EXC_PC_IRQ, TRAP_USER, 5'd7, 32'h0, 32'd0, 0);
    add_exp(32'h21c, fill_word(32'h21c), 1'b0, 1'b0, 1'b0);
    add_exp(32'h220, fill_word(32'h220), 1'b0, 1'b0, 1'b0);
    add_row(PC_MRET, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h82, 32'd0, 0);
    add_exp(32'h82, x_big, 1'b0, 1'b0, 1'b0);
    add_exp(32'h86, x_addi, 1'b1, 1'b0, 1'b0);
    add_row(PC_URET, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h98, 32'd0, 0);
    add_exp(32'h98, 32'h0, 1'b1, 1'b1, 1'b0);
    add_exp(32'h9a, x_li, 1'b1, 1'b0, 1'b0);
    // loop 1 spans 0x300 to 0x308
    add_row(PC_JUMP, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h300, 32'd3, 0);
    add_exp(32'h300, fill_word(32'h300), 1'b0, 1'b0, 1'b0);
    add_exp(32'h304, fill_word(32'h304), 1'b0, 1'b0, 1'b0);
    add_exp(32'h308, fill_word(32'h308), 1'b0, 1'b0, 1'b0);
    add_exp(32'h300, fill_word(32'h300), 1'b0, 1'b0, 1'b1);
    add_exp(32'h304, fill_word(32'h304), 1'b0, 1'b0, 1'b0);
    add_row(PC_JUMP, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h300, 32'd1, 0);
    add_exp(32'h300, fill_word(32'h300), 1'b0, 1'b0, 1'b0);
    add_exp(32'h304, fill_word(32'h304), 1'b0, 1'b0, 1'b0);
    add_exp(32'h308, fill_word(32'h308), 1'b0, 1'b0, 1'b0);
    add_exp(32'h30c, fill_word(32'h30c), 1'b0, 1'b0, 1'b0);
    add_row(PC_BOOT, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0, 32'd0, 0);
    add_exp(32'h80, x_li, 1'b1, 1'b0, 1'b0);
    add_exp(32'h82, x_big, 1'b0, 1'b0, 1'b0);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value(instr_req_o, 1'b0, "instr_req_o after reset");
    check_value(instr_valid_id_o, 1'b0, "instr_valid_id_o after reset");
    check_value(is_hwlp_id_o, 1'b0, "is_hwlp_id_o after reset");
    check_value(if_busy_o, 1'b0, "if_busy_o after reset");

    for (int r = 0; r < n_rows; r++) begin
      last          = (r == n_rows - 1) ? n_exp : row_first[r + 1];
      hwlp_cnt_i[1] = row_cnt[r];
      if (r == 0) begin
        req_i = 1'b1;
      end else begin
        pc_mux_i         = row_mux[r];
        exc_pc_mux_i     = row_exc[r];
        trap_addr_mux_i  = row_trap[r];
        exc_vec_pc_mux_i = row_vec[r];
        jump_target_id_i = row_tgt[r];
        jump_target_ex_i = row_tgt[r];
        mepc_i           = row_tgt[r];
        uepc_i           = row_tgt[r];
        pc_set_i         = 1'b1;
      end
      // ID is ready in the redirect cycle, yet nothing may move in
      id_ready_i          = 1'b1;
      clear_instr_valid_i = 1'b1;
      @(negedge clk);
      pc_set_i            = 1'b0;
      id_ready_i          = 1'b0;
      clear_instr_valid_i = 1'b0;
      check_value(instr_valid_id_o, 1'b0, "instr_valid_id_o after redirect");
      check_value(pc_if_o, e_pc[row_first[r]], "pc_if_o after redirect");
      check_value(if_busy_o, 1'b1, "if_busy_o after redirect");
      for (int k = row_first[r]; k < last; k++) begin
        next_instr();
        check_value(pc_id_o, e_pc[k], "pc_id_o");
        check_value(instr_rdata_id_o, e_instr[k], "instr_rdata_id_o");
        check_value(is_compressed_id_o, e_comp[k], "is_compressed_id_o");
        check_value(illegal_c_insn_id_o, e_ill[k], "illegal_c_insn_id_o");
        check_value(is_hwlp_id_o, e_hwlp[k], "is_hwlp_id_o");
        if (e_hwlp[k]) begin
          check_value(hwlp_dec_cnt_id_o, 2'b10, "hwlp_dec_cnt_id_o");
        end
        if ((k == row_first[r]) && (row_stall[r] > 0)) begin
          stall_check(row_stall[r]);
        end
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: verilog.f
rtl/fetch_pkg.sv
rtl/prefetch_buffer.sv
rtl/hwloop_controller.sv
rtl/compressed_decoder.sv
rtl/fetch_stage.sv
tb/tb_fetch_stage.sv
